/* filelist.f */
verilog/spi_pkg.sv
verilog/spi_tx_path.sv
verilog/spi_rx_path.sv
verilog/spi_master.sv
verilog/axi_lite_regs.sv
verilog/spi_bridge_top.sv
verification/tb_spi_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spi_bridge
RTL_TOP   ?= spi_bridge_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

RTL_SRCS := $(filter verilog/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_spi_bridge.sv */
`timescale 1ns/100ps

module tb_spi_bridge;
  import spi_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int CLK_DIV    = 4;
  localparam int RD_GAP     = 20;
  localparam int N_WR       = 8;

  localparam logic [3:0] OFS_CMD    = 4'h0;
  localparam logic [3:0] OFS_STATUS = 4'h4;
  localparam logic [3:0] OFS_RDATA  = 4'h8;
  localparam logic [3:0] OFS_BAD    = 4'hc;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // worst case per command is the frame plus the register traffic around it
  localparam int AXI_OVH     = 40;
  localparam int WR_WORST    = 2 * CLK_DIV * (CMD_W + 1) + AXI_OVH;
  localparam int RD_WORST    = 2 * CLK_DIV * (HDR_W + DATA_W + 2) + RD_GAP + AXI_OVH;
  localparam int TIMEOUT_CYC = 4 * ((N_WR + 3) * WR_WORST + 9 * RD_WORST);

  logic        clk;
  logic        rst_n;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso = 1'b0;

  int value_errs = 0;
  int proto_errs = 0;
  int cycle_cnt  = 0;
  int seed       = 32'h8bf5_613e;

  // spi slave model state
  logic [DATA_W-1:0] init_vals  [8];
  logic [DATA_W-1:0] slave_regs [8];
  logic [CMD_W-1:0]  shift_in   = '0;
  logic [CMD_W-1:0]  last_word  = '0;
  logic [HDR_W-1:0]  hdr_word   = '0;
  logic [DATA_W-1:0] tx_sh      = '0;
  logic [ADDR_W-1:0] rd_addr    = '0;
  logic              rd_pending = 1'b0;
  int                bit_cnt    = 0;
  int                last_bits  = 0;
  int                frame_cnt  = 0;
  int                gap_cycles = 0;
  time               cs_rise_t  = 0;

  // previous cycle copies of the response channels
  logic        bvalid_q;
  logic        bready_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic        rready_q;
  logic [1:0]  rresp_q;
  logic [31:0] rdata_q;

  spi_bridge_top #(
    .CLK_DIV (CLK_DIV),
    .RD_GAP  (RD_GAP)
  ) spi_bridge_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    while (cycle_cnt < TIMEOUT_CYC)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the command sequence did not finish", cycle_cnt);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic void report_mismatch(string name, logic [63:0] exp, logic [63:0] got);
    value_errs++;
    $display("mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
  endfunction

  function automatic void expect_eq(string name, logic [63:0] exp, logic [63:0] got);
    assert (got == exp) else report_mismatch(name, exp, got);
  endfunction

  // ==============================
  // protocol checks
  // ==============================
  always @(posedge clk)
  begin
    bvalid_q <= bvalid;
    bready_q <= bready;
    bresp_q  <= bresp;
    rvalid_q <= rvalid;
    rready_q <= rready;
    rresp_q  <= rresp;
    rdata_q  <= rdata;
  end

  reset_state: assert property (@(negedge clk) !rst_n |-> (cs_n && !sclk && !mosi &&
      !awready && !wready && !arready && !bvalid && !rvalid))
    else
    begin
      proto_errs++;
      $display("outputs left their reset values during reset at %0t", $time);
    end

  sclk_idle: assert property (@(negedge clk) disable iff (!rst_n) cs_n |-> (!sclk && !mosi))
    else
    begin
      proto_errs++;
      $display("sclk or mosi moved while cs_n was high at %0t", $time);
    end

  // outputs only change on the rising edge, so the falling edge sees them settled
  bresp_held: assert property (@(negedge clk) disable iff (!rst_n)
      (bvalid_q && !bready_q) |-> ({bvalid, bresp} == {1'b1, bresp_q}))
    else report_mismatch("bvalid,bresp", 64'({1'b1, bresp_q}), 64'({bvalid, bresp}));

  rdata_held: assert property (@(negedge clk) disable iff (!rst_n)
      (rvalid_q && !rready_q) |-> ({rvalid, rresp, rdata} == {1'b1, rresp_q, rdata_q}))
    else report_mismatch("rvalid,rresp,rdata", 64'({1'b1, rresp_q, rdata_q}),
                         64'({rvalid, rresp, rdata}));

  // ==============================
  // spi slave model
  // ==============================
  initial
  begin
    @(posedge rst_n);
    for (int i = 0; i < 8; i++)
      slave_regs[i] = init_vals[i];
    forever
    begin
      @(negedge cs_n);
      bit_cnt  = 0;
      shift_in = '0;
      if (rd_pending)
      begin
        gap_cycles = int'(($time - cs_rise_t) / CLK_PERIOD);
        tx_sh      = slave_regs[rd_addr];
        miso       = tx_sh[DATA_W-1];  // first bit is ready before the first rise
      end
      while (!cs_n)
      begin
        @(posedge sclk or posedge cs_n);
        if (!cs_n)
        begin
          shift_in = {shift_in[CMD_W-2:0], mosi};
          bit_cnt++;
          @(negedge sclk or posedge cs_n);
          if (!cs_n && rd_pending)
          begin
            tx_sh = {tx_sh[DATA_W-2:0], 1'b0};
            miso  = tx_sh[DATA_W-1];
          end
        end
      end
      cs_rise_t = $time;
      frame_cnt++;
      last_bits = bit_cnt;
      last_word = shift_in;
      if (rd_pending)
      begin
        rd_pending = 1'b0;
        miso       = 1'b0;
      end
      else if ((bit_cnt == HDR_W) && !shift_in[HDR_W-1])
      begin
        rd_pending = 1'b1;
        rd_addr    = shift_in[ADDR_W-1:0];
        hdr_word   = shift_in[HDR_W-1:0];
      end
      else if ((bit_cnt == CMD_W) && shift_in[CMD_W-1])
        slave_regs[shift_in[CMD_W-2 -: ADDR_W]] = shift_in[DATA_W-1:0];
    end
  end

  // ==============================
  // axi driver
  // ==============================
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] value, input int hold,
                           output logic [1:0] resp);
    awaddr  <= addr;
    wdata   <= value;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do
      @(negedge clk);
    while (!awready);
    expect_eq("wready", 64'(1), 64'(wready));  // raised together with awready
    @(negedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    while (!bvalid)
      @(negedge clk);
    repeat (hold) @(negedge clk);  // bready stays low, the response must wait
    resp = bresp;
    bready <= 1'b1;
    @(negedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, input int hold, output logic [31:0] value,
                          output logic [1:0] resp);
    araddr  <= addr;
    arvalid <= 1'b1;
    do
      @(negedge clk);
    while (!arready);
    @(negedge clk);
    arvalid <= 1'b0;
    while (!rvalid)
      @(negedge clk);
    repeat (hold) @(negedge clk);
    value = rdata;
    resp  = rresp;
    rready <= 1'b1;
    @(negedge clk);
    rready <= 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    logic [1:0]  resp;
    status = 32'h1;
    while (status[0])
      read_reg(OFS_STATUS, 0, status, resp);
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial
  begin
    logic [CMD_W-1:0] cmd;
    logic [CMD_W-1:0] cmd2;
    logic [31:0]      data;
    logic [1:0]       resp;
    int               frames;
    rst_n   <= 1'b0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    for (int i = 0; i < 8; i++)
      init_vals[i] = DATA_W'($random(seed));
    repeat (2) @(negedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_eq("cs_n,sclk,mosi", 64'(3'b100), 64'({cs_n, sclk, mosi}));
    expect_eq("bvalid,rvalid", 64'(0), 64'({bvalid, rvalid}));
    read_reg(OFS_STATUS, 0, data, resp);
    expect_eq("STATUS after reset", 64'(0), 64'(data));

    for (int n = 0; n < N_WR; n++)
    begin
      cmd = CMD_W'($random(seed));
      cmd[CMD_W-1] = OP_WRITE;  // op flag set for a write
      frames = frame_cnt;
      write_reg(OFS_CMD, 32'(cmd), 0, resp);
      expect_eq("bresp CMD", 64'(RESP_OKAY), 64'(resp));
      wait_idle();
      expect_eq("frame count", 64'(frames + 1), 64'(frame_cnt));
      expect_eq("write frame bits", 64'(CMD_W), 64'(last_bits));
      expect_eq("write frame word", 64'(cmd), 64'(last_word));
      expect_eq("slave register", 64'(cmd[DATA_W-1:0]),
                64'(slave_regs[cmd[CMD_W-2 -: ADDR_W]]));
    end

    for (int i = 0; i < 8; i++)
    begin
      cmd = {OP_READ, ADDR_W'(i), DATA_W'(0)};
      frames = frame_cnt;
      write_reg(OFS_CMD, 32'(cmd), 0, resp);
      expect_eq("bresp CMD", 64'(RESP_OKAY), 64'(resp));
      wait_idle();
      expect_eq("frame count", 64'(frames + 2), 64'(frame_cnt));
      expect_eq("read header", 64'({OP_READ, ADDR_W'(i)}), 64'(hdr_word));
      expect_eq("read frame bits", 64'(DATA_W), 64'(last_bits));
      assert (gap_cycles >= RD_GAP)
      else
      begin
        proto_errs++;
        $display("read gap of %0d cycles is shorter than %0d", gap_cycles, RD_GAP);
      end
      read_reg(OFS_STATUS, 0, data, resp);
      expect_eq("STATUS after read", 64'(2), 64'(data));
      read_reg(OFS_RDATA, 0, data, resp);
      expect_eq("RDATA", 64'(slave_regs[i]), 64'(data));
      read_reg(OFS_STATUS, 0, data, resp);
      expect_eq("STATUS after RDATA", 64'(0), 64'(data));
    end

    // second command lands while the first frame is still running
    cmd  = CMD_W'($random(seed));
    cmd2 = CMD_W'($random(seed));
    cmd[CMD_W-1]  = OP_WRITE;
    cmd2[CMD_W-1] = OP_WRITE;
    frames = frame_cnt;
    write_reg(OFS_CMD, 32'(cmd), 0, resp);
    expect_eq("bresp CMD", 64'(RESP_OKAY), 64'(resp));
    write_reg(OFS_CMD, 32'(cmd2), 0, resp);
    expect_eq("bresp CMD while busy", 64'(RESP_SLVERR), 64'(resp));
    wait_idle();
    expect_eq("frame count", 64'(frames + 1), 64'(frame_cnt));
    expect_eq("write frame word", 64'(cmd), 64'(last_word));

    write_reg(OFS_BAD, 32'h5a, 0, resp);
    expect_eq("bresp 0xC", 64'(RESP_SLVERR), 64'(resp));
    read_reg(OFS_BAD, 0, data, resp);
    expect_eq("rresp 0xC", 64'(RESP_SLVERR), 64'(resp));
    expect_eq("rdata 0xC", 64'(0), 64'(data));

    cmd = {OP_WRITE, ADDR_W'(5), DATA_W'($random(seed))};
    write_reg(OFS_CMD, 32'(cmd), 6, resp);
    expect_eq("bresp held CMD", 64'(RESP_OKAY), 64'(resp));
    wait_idle();
    cmd = {OP_READ, ADDR_W'(5), DATA_W'(0)};
    write_reg(OFS_CMD, 32'(cmd), 0, resp);
    wait_idle();
    read_reg(OFS_RDATA, 6, data, resp);
    expect_eq("RDATA held", 64'(slave_regs[5]), 64'(data));
    expect_eq("rresp held", 64'(RESP_OKAY), 64'(resp));
    read_reg(OFS_BAD, 5, data, resp);
    expect_eq("rresp held 0xC", 64'(RESP_SLVERR), 64'(resp));

    $display("checks done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
    if ((value_errs == 0) && (proto_errs == 0))
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* verilog/spi_bridge_top.sv */
`timescale 1ns/100ps

module spi_bridge_top #(
  parameter int CLK_DIV = 4,    // clk cycles per sclk half period, at least 2
  parameter int RD_GAP  = 100
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  output logic        sclk,
  output logic        cs_n,
  output logic        mosi,
  input  logic        miso
);
  import spi_pkg::*;

  logic              cmd_start;
  logic [CMD_W-1:0]  cmd_word;
  logic              busy;
  logic              rd_done;
  logic [DATA_W-1:0] rd_byte;

  axi_lite_regs axi_lite_regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word),
    .busy      (busy),
    .rd_done   (rd_done),
    .rd_byte   (rd_byte)
  );

  spi_master #(
    .CLK_DIV (CLK_DIV),
    .RD_GAP  (RD_GAP)
  ) spi_master_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word),
    .busy      (busy),
    .rd_done   (rd_done),
    .rd_byte   (rd_byte),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

endmodule

/* verilog/axi_lite_regs.sv */
`timescale 1ns/100ps

module axi_lite_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [3:0]                  awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [31:0]                 wdata,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [3:0]                  araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [31:0]                 rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  output logic                        cmd_start,
  output logic [spi_pkg::CMD_W-1:0]   cmd_word,
  input  logic                        busy,
  input  logic                        rd_done,
  input  logic [spi_pkg::DATA_W-1:0]  rd_byte
);
  import spi_pkg::*;

  localparam logic [3:0] OFS_CMD    = 4'h0;
  localparam logic [3:0] OFS_STATUS = 4'h4;
  localparam logic [3:0] OFS_RDATA  = 4'h8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic              wr_stage;
  logic              rd_stage;
  logic [3:0]        wr_addr;
  logic [CMD_W-1:0]  wr_data;
  logic [3:0]        rd_addr;
  logic              cmd_ok;
  logic              rd_valid;
  logic [DATA_W-1:0] rd_hold;
  spi_op_e           start_op;

  assign cmd_ok   = !busy && !cmd_start;  // one command in flight
  assign start_op = spi_op_e'(cmd_word[CMD_W-1]);

  // ==============================
  // write channel
  // ==============================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
    end
    else
    begin
      awready <= awvalid && wvalid && !awready && !wr_stage && !bvalid;
      wready  <= awvalid && wvalid && !awready && !wr_stage && !bvalid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (awready && awvalid && wvalid)
    begin
      wr_addr <= awaddr;
      wr_data <= wdata[CMD_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_stage  <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= RESP_OKAY;
      cmd_start <= 1'b0;
    end
    else
    begin
      wr_stage  <= awready && awvalid && wvalid;
      cmd_start <= 1'b0;
      if (wr_stage)
      begin
        bvalid <= 1'b1;
        case (wr_addr)
          OFS_CMD:
          begin
            bresp     <= cmd_ok ? RESP_OKAY : RESP_SLVERR;
            cmd_start <= cmd_ok;
          end
          OFS_STATUS, OFS_RDATA: bresp <= RESP_OKAY;  // read only, write ignored
          default: bresp <= RESP_SLVERR;
        endcase
      end
      else if (bvalid && bready)
      begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_stage && (wr_addr == OFS_CMD) && cmd_ok)
    begin
      cmd_word <= wr_data;
    end
  end

  // ==============================
  // read data flag
  // ==============================
  // a new byte wins over a clearing read in the same cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rd_valid <= 1'b0;
    else if (rd_done)
      rd_valid <= 1'b1;
    else if (rd_stage && (rd_addr == OFS_RDATA))
      rd_valid <= 1'b0;
    else if (cmd_start && (start_op == OP_READ))
      rd_valid <= 1'b0;  // the held byte goes stale once a new read starts
  end

  always_ff @(posedge clk)
  begin
    if (rd_done)
      rd_hold <= rd_byte;
  end

  // ==============================
  // read channel
  // ==============================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      arready <= 1'b0;
    else
      arready <= arvalid && !arready && !rd_stage && !rvalid;
  end

  always_ff @(posedge clk)
  begin
    if (arready && arvalid)
      rd_addr <= araddr;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_stage <= 1'b0;
      rvalid   <= 1'b0;
      rresp    <= RESP_OKAY;
      rdata    <= '0;
    end
    else
    begin
      rd_stage <= arready && arvalid;
      if (rd_stage)
      begin
        rvalid <= 1'b1;
        rresp  <= RESP_OKAY;
        case (rd_addr)
          OFS_CMD:    rdata <= {{(32-CMD_W){1'b0}}, cmd_word};
          OFS_STATUS: rdata <= {30'b0, rd_valid, busy};
          OFS_RDATA:  rdata <= {{(32-DATA_W){1'b0}}, rd_hold};
          default:
          begin
            rdata <= '0;
            rresp <= RESP_SLVERR;
          end
        endcase
      end
      else if (rvalid && rready)
      begin
        rvalid <= 1'b0;  // rdata and rresp hold until then
      end
    end
  end

endmodule

/* verilog/spi_master.sv */
`timescale 1ns/100ps

module spi_master #(
  parameter int CLK_DIV = 4,
  parameter int RD_GAP  = 100
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_start,
  input  logic [spi_pkg::CMD_W-1:0]   cmd_word,
  output logic                        busy,
  output logic                        rd_done,
  output logic [spi_pkg::DATA_W-1:0]  rd_byte,
  output logic                        sclk,
  output logic                        cs_n,
  output logic                        mosi,
  input  logic                        miso
);
  import spi_pkg::*;

  localparam int DIV_W = (CLK_DIV > 2) ? $clog2(CLK_DIV) : 1;
  localparam int GAP_W = $clog2(RD_GAP + 1);
  localparam int BIT_W = $clog2(CMD_W + 1);

  spi_state_e        state;
  spi_state_e        state_nxt;
  spi_op_e           op;
  logic [DIV_W-1:0]  div_cnt;
  logic [GAP_W-1:0]  gap_cnt;
  logic [BIT_W-1:0]  bit_cnt;
  logic [BIT_W-1:0]  phase_len;
  logic              first_q;
  logic              in_shift;
  logic              tx_active;
  logic              phase_start;
  logic              tick;
  logic              rise_tick;
  logic              fall_tick;
  logic              phase_done;
  logic              gap_done;
  logic              tx_mosi;
  logic [DATA_W-1:0] rx_byte;

  assign op        = spi_op_e'(cmd_word[CMD_W-1]);
  assign tx_active = (state == ST_WR_SHIFT) || (state == ST_HDR_SHIFT);
  assign in_shift  = tx_active || (state == ST_RD_SHIFT);

  assign busy = (state != ST_IDLE);
  assign cs_n = !in_shift;
  assign mosi = tx_active && tx_mosi;  // low in the gap and the read data phase

  always_comb
  begin
    case (state)
      ST_WR_SHIFT:  phase_len = BIT_W'(CMD_W);
      ST_HDR_SHIFT: phase_len = BIT_W'(HDR_W);
      default:      phase_len = BIT_W'(DATA_W);
    endcase
  end

  // ==============================
  // bit timing
  // ==============================
  // sclk toggles every CLK_DIV cycles, the last rise is replaced by the phase end
  assign tick       = in_shift && (div_cnt == DIV_W'(CLK_DIV - 1));
  assign rise_tick  = tick && !sclk && (bit_cnt != phase_len);
  assign phase_done = tick && !sclk && (bit_cnt == phase_len);
  assign fall_tick  = in_shift && (first_q || (tick && sclk));
  assign gap_done   = (state == ST_GAP) && (gap_cnt == GAP_W'(RD_GAP - 1));

  assign phase_start = (state_nxt != state) &&
                       ((state_nxt == ST_WR_SHIFT) || (state_nxt == ST_HDR_SHIFT) ||
                        (state_nxt == ST_RD_SHIFT));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      first_q <= 1'b0;
    end
    else if (phase_start)
    begin
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      first_q <= 1'b1;  // gives the opening fall_tick so mosi settles before the first rise
    end
    else if (in_shift)
    begin
      first_q <= 1'b0;
      if (tick)
      begin
        div_cnt <= '0;
        if (!phase_done)
          sclk <= ~sclk;
      end
      else
      begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (rise_tick)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      gap_cnt <= '0;
    else if ((state == ST_GAP) && !gap_done)
      gap_cnt <= gap_cnt + 1'b1;
    else
      gap_cnt <= '0;
  end

  // ==============================
  // frame sequence
  // ==============================
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (cmd_start && (op == OP_WRITE))
          state_nxt = ST_WR_SHIFT;
        else if (cmd_start)
          state_nxt = ST_HDR_SHIFT;
      end
      ST_WR_SHIFT:  if (phase_done) state_nxt = ST_WR_END;
      ST_WR_END:    state_nxt = ST_IDLE;
      ST_HDR_SHIFT: if (phase_done) state_nxt = ST_GAP;
      ST_GAP:       if (gap_done) state_nxt = ST_RD_SHIFT;
      ST_RD_SHIFT:  if (phase_done) state_nxt = ST_RD_END;
      ST_RD_END:    state_nxt = ST_IDLE;
      default:      state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rd_done <= 1'b0;
    else
      rd_done <= (state == ST_RD_END);  // one cycle after cs_n goes back high
  end

  always_ff @(posedge clk)
  begin
    if ((state == ST_RD_SHIFT) && phase_done)
      rd_byte <= rx_byte;
  end

  spi_tx_path spi_tx_path_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (cmd_start && (state == ST_IDLE)),
    .load_word (cmd_word),
    .shift     (fall_tick && tx_active),
    .mosi      (tx_mosi)
  );

  spi_rx_path spi_rx_path_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (gap_done),
    .sample  (rise_tick && (state == ST_RD_SHIFT)),
    .miso    (miso),
    .rx_byte (rx_byte)
  );

endmodule

/* verilog/spi_rx_path.sv */
`timescale 1ns/100ps

module spi_rx_path (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clear,
  input  logic                        sample,
  input  logic                        miso,
  output logic [spi_pkg::DATA_W-1:0]  rx_byte
);
  import spi_pkg::*;

  // first bit sampled ends up as the msb after DATA_W samples
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_byte <= '0;
    else if (clear)
      rx_byte <= '0;
    else if (sample)
      rx_byte <= {rx_byte[DATA_W-2:0], miso};
  end

endmodule

/* verilog/spi_tx_path.sv */
`timescale 1ns/100ps

module spi_tx_path (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       load,
  input  logic [spi_pkg::CMD_W-1:0]  load_word,
  input  logic                       shift,
  output logic                       mosi
);
  import spi_pkg::*;

  logic [CMD_W-1:0] tx_sr;

  // the read header is bits 11:8 of the command, so one load serves both frame types
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_sr <= '0;
      mosi  <= 1'b0;
    end
    else if (load)
    begin
      tx_sr <= load_word;
      mosi  <= 1'b0;
    end
    else if (shift)
    begin
      mosi  <= tx_sr[CMD_W-1];  // msb first
      tx_sr <= {tx_sr[CMD_W-2:0], 1'b0};
    end
  end

endmodule

/* verilog/spi_pkg.sv */
package spi_pkg;

  // ==============================
  // command word layout
  // ==============================
  // bit 11 is the op flag, bits 10:8 the register address, bits 7:0 the data
  localparam int CMD_W  = 12;
  localparam int ADDR_W = 3;
  localparam int DATA_W = 8;
  localparam int HDR_W  = 1 + ADDR_W;  // op flag plus address, sent alone on a read

  // ==============================
  // enums
  // ==============================
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  // a read splits into header, gap and data phases with cs_n high in the gap
  typedef enum logic [2:0]
  {
    ST_IDLE      = 3'd0,
    ST_WR_SHIFT  = 3'd1,
    ST_WR_END    = 3'd2,
    ST_HDR_SHIFT = 3'd3,
    ST_GAP       = 3'd4,
    ST_RD_SHIFT  = 3'd5,
    ST_RD_END    = 3'd6
  } spi_state_e;

endpackage
